// File: rtl/rv32i_types.sv
package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // sub and sra sit on the slt/sltu codes
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic {pcmux_plus4, pcmux_alu} pcmux_t;
    typedef enum logic {alumux1_rs1, alumux1_pc} alumux1_t;

    typedef enum logic [2:0] {
        alumux2_i_imm,
        alumux2_u_imm,
        alumux2_b_imm,
        alumux2_s_imm,
        alumux2_j_imm,
        alumux2_rs2
    } alumux2_t;

    typedef enum logic {cmpmux_rs2, cmpmux_i_imm} cmpmux_t;

    typedef enum logic [3:0] {
        regfilemux_alu_out,
        regfilemux_br_en,
        regfilemux_u_imm,
        regfilemux_pc_plus4,
        regfilemux_lb,
        regfilemux_lbu,
        regfilemux_lh,
        regfilemux_lhu,
        regfilemux_lw
    } regfilemux_t;

    typedef enum logic {marmux_pc, marmux_alu} marmux_t;

    typedef struct packed {
        rv32i_opcode    opcode;
        logic [2:0]     funct3;
        logic [6:0]     funct7;
        logic           mem_read;
        logic           mem_write;
        logic           load_regfile;
        pcmux_t         pcmux_sel;
        alumux1_t       alumux1_sel;
        alumux2_t       alumux2_sel;
        cmpmux_t        cmpmux_sel;
        regfilemux_t    regfilemux_sel;
        marmux_t        marmux_sel;
        alu_ops         aluop;
        branch_funct3_t cmpop;
        logic [3:0]     mem_byte_en; // unshifted
        logic           illegal;
    } rv32i_control_word;

    typedef struct packed {
        rv32i_word         pc;
        rv32i_reg          rd;
        rv32i_word         rs1_val;
        rv32i_word         rs2_val;
        rv32i_word         i_imm;
        rv32i_word         s_imm;
        rv32i_word         b_imm;
        rv32i_word         uj_imm; // j_imm for jal, u_imm otherwise
        rv32i_control_word ctrl;
    } decode_item_t;

    typedef struct packed {
        rv32i_word  pc;
        rv32i_word  next_pc;
        rv32i_reg   rd;
        logic       rd_we;
        rv32i_word  rd_value;
        logic       load_pending;
        logic       mem_read;
        logic       mem_write;
        rv32i_word  mem_addr;
        rv32i_word  mem_wdata;
        logic [3:0] mem_byte_en;
        logic       illegal;
    } retire_t;

endpackage

// File: rtl/control_rom.sv
`timescale 1ns/10ps

module control_rom
    import rv32i_types::*;
(
    input  rv32i_opcode       opcode,
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    output rv32i_control_word ctrl
);
    branch_funct3_t branch_funct3;
    load_funct3_t   load_funct3;
    store_funct3_t  store_funct3;
    arith_funct3_t  arith_funct3;

    assign branch_funct3 = branch_funct3_t'(funct3);
    assign load_funct3   = load_funct3_t'(funct3);
    assign store_funct3  = store_funct3_t'(funct3);
    assign arith_funct3  = arith_funct3_t'(funct3);

    always_comb begin
        // defaults first, each opcode overrides
        ctrl.opcode         = opcode;
        ctrl.funct3         = funct3;
        ctrl.funct7         = funct7;
        ctrl.mem_read       = 1'b0;
        ctrl.mem_write      = 1'b0;
        ctrl.load_regfile   = 1'b0;
        ctrl.pcmux_sel      = pcmux_plus4;
        ctrl.alumux1_sel    = alumux1_rs1;
        ctrl.alumux2_sel    = alumux2_i_imm;
        ctrl.cmpmux_sel     = cmpmux_rs2;
        ctrl.regfilemux_sel = regfilemux_alu_out;
        ctrl.marmux_sel     = marmux_pc;
        ctrl.aluop          = alu_add;
        ctrl.cmpop          = beq;
        ctrl.mem_byte_en    = 4'b1111;
        ctrl.illegal        = 1'b0;

        unique case (opcode)
            op_lui: begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = regfilemux_u_imm;
            end
            op_auipc: begin
                ctrl.alumux1_sel  = alumux1_pc;
                ctrl.alumux2_sel  = alumux2_u_imm;
                ctrl.load_regfile = 1'b1;
            end
            op_jal: begin
                ctrl.pcmux_sel      = pcmux_alu;
                ctrl.alumux1_sel    = alumux1_pc;
                ctrl.alumux2_sel    = alumux2_j_imm;
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end
            op_jalr: begin
                ctrl.pcmux_sel      = pcmux_alu;
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end
            op_br: begin
                ctrl.alumux1_sel = alumux1_pc; // target = pc + b_imm
                ctrl.alumux2_sel = alumux2_b_imm;
                unique case (branch_funct3)
                    beq, bne, blt, bge, bltu, bgeu: ctrl.cmpop = branch_funct3;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_load: begin
                ctrl.marmux_sel   = marmux_alu;
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read     = 1'b1;
                unique case (load_funct3)
                    lb:      ctrl.regfilemux_sel = regfilemux_lb;
                    lbu:     ctrl.regfilemux_sel = regfilemux_lbu;
                    lh:      ctrl.regfilemux_sel = regfilemux_lh;
                    lhu:     ctrl.regfilemux_sel = regfilemux_lhu;
                    lw:      ctrl.regfilemux_sel = regfilemux_lw;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_store: begin
                ctrl.marmux_sel  = marmux_alu;
                ctrl.alumux2_sel = alumux2_s_imm;
                ctrl.mem_write   = 1'b1;
                unique case (store_funct3)
                    sb:      ctrl.mem_byte_en = 4'b0001;
                    sh:      ctrl.mem_byte_en = 4'b0011;
                    sw:      ctrl.mem_byte_en = 4'b1111;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_imm, op_reg: begin
                ctrl.load_regfile = 1'b1;
                if (opcode == op_reg) begin
                    ctrl.alumux2_sel = alumux2_rs2;
                end else begin
                    ctrl.cmpmux_sel = cmpmux_i_imm; // slti/sltiu compare against imm
                end
                unique case (arith_funct3)
                    sr:   ctrl.aluop = funct7[5] ? alu_sra : alu_srl;
                    slt: begin
                        ctrl.cmpop          = blt;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    sltu: begin
                        ctrl.cmpop          = bltu;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    add: begin
                        // only the register form has sub
                        if (opcode == op_reg && funct7[5]) begin
                            ctrl.aluop = alu_sub;
                        end
                    end
                    default: ctrl.aluop = alu_ops'(funct3);
                endcase
            end
            default: ctrl.illegal = 1'b1;
        endcase

        if (ctrl.illegal) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

    always_comb begin
        assert (!(ctrl.mem_read && ctrl.mem_write))
            else $error("control word asks for a read and a write together");
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/10ps

module regfile
    import rv32i_types::*;
#(
    parameter int XLEN       = 32,
    parameter int RESET_REGS = 1
) (
    input  logic            clk,
    input  logic            rst_n,
    input  rv32i_reg        rs1_addr,
    input  rv32i_reg        rs2_addr,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    input  logic            wr_en,
    input  rv32i_reg        wr_addr,
    input  logic [XLEN-1:0] wr_data
);
    logic [XLEN-1:0] regs [32];

    if (RESET_REGS != 0) begin : g_reset
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                for (int i = 0; i < 32; i++) begin
                    regs[i] <= '0;
                end
            end else if (wr_en && wr_addr != '0) begin
                regs[wr_addr] <= wr_data;
            end
        end
    end else begin : g_no_reset
        always_ff @(posedge clk) begin
            if (wr_en && wr_addr != '0) begin
                regs[wr_addr] <= wr_data;
            end
        end
    end

    // x0 forced to zero on read
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
    import rv32i_types::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic [XLEN-1:0] in_pc,
    input  rv32i_word       in_instr,
    output rv32i_reg        rs1_addr,
    output rv32i_reg        rs2_addr,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic            dec_valid,
    input  logic            dec_ready,
    output decode_item_t    dec_item
);
    rv32i_control_word ctrl;
    rv32i_word         i_imm;
    rv32i_word         s_imm;
    rv32i_word         b_imm;
    rv32i_word         u_imm;
    rv32i_word         j_imm;
    decode_item_t      item_next;
    logic              started;
    logic              hazard;
    logic              take;

    assign rs1_addr = in_instr[19:15];
    assign rs2_addr = in_instr[24:20];

    control_rom u_control_rom (
        .opcode (rv32i_opcode'(in_instr[6:0])),
        .funct3 (in_instr[14:12]),
        .funct7 (in_instr[31:25]),
        .ctrl   (ctrl)
    );

    assign i_imm = {{21{in_instr[31]}}, in_instr[30:20]};
    assign s_imm = {{21{in_instr[31]}}, in_instr[30:25], in_instr[11:7]};
    assign b_imm = {{20{in_instr[31]}}, in_instr[7], in_instr[30:25], in_instr[11:8], 1'b0};
    assign u_imm = {in_instr[31:12], 12'h000};
    assign j_imm = {{12{in_instr[31]}}, in_instr[19:12], in_instr[20], in_instr[30:21], 1'b0};

    // the held item writes the regfile only when it moves on, so wait for it
    assign hazard = dec_valid && dec_item.ctrl.load_regfile
                    && dec_item.ctrl.opcode != op_load && dec_item.rd != '0
                    && (rs1_addr == dec_item.rd || rs2_addr == dec_item.rd);

    assign in_ready = started && !(dec_valid && !dec_ready) && !hazard;
    assign take     = in_valid && in_ready;

    always_comb begin
        item_next.pc      = in_pc;
        item_next.rd      = in_instr[11:7];
        item_next.rs1_val = rs1_data;
        item_next.rs2_val = rs2_data;
        item_next.i_imm   = i_imm;
        item_next.s_imm   = s_imm;
        item_next.b_imm   = b_imm;
        item_next.uj_imm  = (ctrl.opcode == op_jal) ? j_imm : u_imm;
        item_next.ctrl    = ctrl;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started   <= 1'b0; // holds in_ready low through reset
            dec_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (take) begin
                dec_valid <= 1'b1;
            end else if (dec_ready) begin
                dec_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dec_item <= item_next;
        end
    end

    a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_item))
        else $error("decode item changed while stalled");

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
    import rv32i_types::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dec_valid,
    output logic            dec_ready,
    input  decode_item_t    dec_item,
    output logic            wr_en,
    output rv32i_reg        wr_addr,
    output logic [XLEN-1:0] wr_data,
    output logic            out_valid,
    input  logic            out_ready,
    output retire_t         out_rec
);
    rv32i_control_word ctrl;
    rv32i_word         alu_a;
    rv32i_word         alu_b;
    rv32i_word         alu_out;
    rv32i_word         cmp_b;
    rv32i_word         pc_plus4;
    rv32i_word         wb_value;
    rv32i_word         mem_addr;
    logic              br_en;
    logic              is_load;
    logic              rd_we;
    logic              take;
    retire_t           rec_next;

    assign ctrl     = dec_item.ctrl;
    assign pc_plus4 = dec_item.pc + 32'd4;

    always_comb begin
        alu_a = (ctrl.alumux1_sel == alumux1_pc) ? dec_item.pc : dec_item.rs1_val;
        unique case (ctrl.alumux2_sel)
            alumux2_u_imm, alumux2_j_imm: alu_b = dec_item.uj_imm;
            alumux2_b_imm: alu_b = dec_item.b_imm;
            alumux2_s_imm: alu_b = dec_item.s_imm;
            alumux2_rs2:   alu_b = dec_item.rs2_val;
            default:       alu_b = dec_item.i_imm;
        endcase
    end

    always_comb begin
        unique case (ctrl.aluop)
            alu_sll: alu_out = alu_a << alu_b[4:0];
            alu_sra: alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            alu_sub: alu_out = alu_a - alu_b;
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_srl: alu_out = alu_a >> alu_b[4:0];
            alu_or:  alu_out = alu_a | alu_b;
            alu_and: alu_out = alu_a & alu_b;
            default: alu_out = alu_a + alu_b;
        endcase
    end

    // rs1 always on the comparator's left
    always_comb begin
        cmp_b = (ctrl.cmpmux_sel == cmpmux_i_imm) ? dec_item.i_imm : dec_item.rs2_val;
        unique case (ctrl.cmpop)
            bne:     br_en = dec_item.rs1_val != cmp_b;
            blt:     br_en = $signed(dec_item.rs1_val) < $signed(cmp_b);
            bge:     br_en = $signed(dec_item.rs1_val) >= $signed(cmp_b);
            bltu:    br_en = dec_item.rs1_val < cmp_b;
            bgeu:    br_en = dec_item.rs1_val >= cmp_b;
            default: br_en = dec_item.rs1_val == cmp_b;
        endcase
    end

    assign is_load = ctrl.regfilemux_sel inside {regfilemux_lb, regfilemux_lbu,
                     regfilemux_lh, regfilemux_lhu, regfilemux_lw};
    assign rd_we   = ctrl.load_regfile && !is_load && !ctrl.illegal && dec_item.rd != '0;

    always_comb begin
        unique case (ctrl.regfilemux_sel)
            regfilemux_alu_out:  wb_value = alu_out;
            regfilemux_br_en:    wb_value = rv32i_word'(br_en);
            regfilemux_u_imm:    wb_value = dec_item.uj_imm;
            regfilemux_pc_plus4: wb_value = pc_plus4;
            default:             wb_value = '0; // load data comes back later
        endcase
    end

    assign mem_addr = (ctrl.marmux_sel == marmux_alu) ? alu_out : dec_item.pc;

    always_comb begin
        rec_next.pc       = dec_item.pc;
        rec_next.next_pc  = pc_plus4;
        if (ctrl.opcode == op_jalr) begin
            rec_next.next_pc = {alu_out[XLEN-1:1], 1'b0};
        end else if (ctrl.pcmux_sel == pcmux_alu || (ctrl.opcode == op_br && br_en)) begin
            rec_next.next_pc = alu_out;
        end
        rec_next.rd           = dec_item.rd;
        rec_next.rd_we        = rd_we;
        rec_next.rd_value     = rd_we ? wb_value : '0;
        rec_next.load_pending = ctrl.mem_read;
        rec_next.mem_read     = ctrl.mem_read;
        rec_next.mem_write    = ctrl.mem_write;
        rec_next.mem_addr     = mem_addr;
        rec_next.mem_wdata    = '0;
        rec_next.mem_byte_en  = 4'b0000;
        if (ctrl.mem_write) begin
            rec_next.mem_wdata = dec_item.rs2_val << {mem_addr[1:0], 3'b000};
        end
        if (ctrl.mem_read || ctrl.mem_write) begin
            rec_next.mem_byte_en = ctrl.mem_byte_en << mem_addr[1:0];
        end
        rec_next.illegal = ctrl.illegal;
    end

    assign dec_ready = !(out_valid && !out_ready);
    assign take      = dec_valid && dec_ready;

    // regfile write lines up with the capture into out_rec
    assign wr_en   = take && rd_we;
    assign wr_addr = dec_item.rd;
    assign wr_data = rec_next.rd_value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_rec <= rec_next;
        end
    end

    a_wr_x0: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_addr != '0)
        else $error("regfile write to x0");

endmodule

// File: rtl/rv32i_datapath.sv
`timescale 1ns/10ps

module rv32i_datapath
    import rv32i_types::*;
#(
    parameter int XLEN       = 32,
    parameter int RESET_REGS = 1
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic [XLEN-1:0] in_pc,
    input  rv32i_word       in_instr,
    output logic            out_valid,
    input  logic            out_ready,
    output retire_t         out_rec
);
    rv32i_reg        rs1_addr;
    rv32i_reg        rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            dec_valid;
    logic            dec_ready;
    decode_item_t    dec_item;
    logic            wr_en;
    rv32i_reg        wr_addr;
    logic [XLEN-1:0] wr_data;

    decode_stage #(
        .XLEN (XLEN)
    ) u_decode_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pc     (in_pc),
        .in_instr  (in_instr),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_item  (dec_item)
    );

    execute_stage #(
        .XLEN (XLEN)
    ) u_execute_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_item  (dec_item),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rec   (out_rec)
    );

    regfile #(
        .XLEN       (XLEN),
        .RESET_REGS (RESET_REGS)
    ) u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

endmodule

// File: test/result_checker.sv
`timescale 1ns/10ps

module result_checker
    import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  logic      in_ready,
    input  rv32i_word in_pc,
    input  rv32i_word in_instr,
    input  logic      out_valid,
    input  logic      out_ready,
    input  retire_t   out_rec,
    output int        mismatches,
    output int        other_errors,
    output int        pending
);
    rv32i_word regs [32]; // architectural state, program order
    retire_t   expected [$];
    retire_t   exp_rec;
    logic      reset_seen;

    initial begin
        mismatches   = 0;
        other_errors = 0;
        pending      = 0;
        reset_seen   = 1'b0;
    end

    function automatic logic branch_taken(logic [2:0] f3, rv32i_word x, rv32i_word y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    function automatic rv32i_word arith(logic [2:0] f3, logic alt, rv32i_word x, rv32i_word y);
        case (f3)
            3'b000: begin
                if (alt) return x - y;
                return x + y;
            end
            3'b001: return x << y[4:0];
            3'b010: return {31'b0, $signed(x) < $signed(y)};
            3'b011: return {31'b0, x < y};
            3'b100: return x ^ y;
            3'b101: begin
                if (alt) return $signed(x) >>> y[4:0];
                return x >> y[4:0];
            end
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    // predicts one record and updates the model registers
    function automatic retire_t run_model(rv32i_word pc, rv32i_word instr);
        retire_t    r;
        rv32i_word  a;
        rv32i_word  b;
        rv32i_word  imm_i;
        rv32i_word  imm_s;
        rv32i_word  imm_b;
        rv32i_word  imm_u;
        rv32i_word  imm_j;
        rv32i_word  addr;
        rv32i_word  val;
        logic [2:0] f3;
        logic [3:0] ben;
        logic       wr;
        f3    = instr[14:12];
        a     = (instr[19:15] == 5'd0) ? '0 : regs[instr[19:15]];
        b     = (instr[24:20] == 5'd0) ? '0 : regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'h000};
        imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        r          = '0;
        r.pc       = pc;
        r.next_pc  = pc + 32'd4;
        r.rd       = instr[11:7];
        r.mem_addr = pc; // address mux rests on pc
        wr         = 1'b0;
        val        = '0;
        case (instr[6:0])
            op_lui: begin
                wr  = 1'b1;
                val = imm_u;
            end
            op_auipc: begin
                wr  = 1'b1;
                val = pc + imm_u;
            end
            op_jal: begin
                wr        = 1'b1;
                val       = pc + 32'd4;
                r.next_pc = pc + imm_j;
            end
            op_jalr: begin
                wr        = 1'b1;
                val       = pc + 32'd4;
                r.next_pc = (a + imm_i) & ~32'd1;
            end
            op_br: begin
                if (f3 == 3'b010 || f3 == 3'b011) r.illegal = 1'b1;
                else if (branch_taken(f3, a, b)) r.next_pc = pc + imm_b;
            end
            op_load: begin
                if (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111) begin
                    r.illegal = 1'b1;
                end else begin
                    addr           = a + imm_i;
                    r.mem_read     = 1'b1;
                    r.load_pending = 1'b1;
                    r.mem_addr     = addr;
                    r.mem_byte_en  = 4'b1111 << addr[1:0];
                end
            end
            op_store: begin
                if (f3 > 3'b010) begin
                    r.illegal = 1'b1;
                end else begin
                    addr          = a + imm_s;
                    ben           = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
                    r.mem_write   = 1'b1;
                    r.mem_addr    = addr;
                    r.mem_wdata   = b << {addr[1:0], 3'b000};
                    r.mem_byte_en = ben << addr[1:0];
                end
            end
            op_imm: begin
                wr  = 1'b1;
                val = arith(f3, instr[30] && f3 == 3'b101, a, imm_i); // no subi
            end
            op_reg: begin
                wr  = 1'b1;
                val = arith(f3, instr[30], a, b);
            end
            default: r.illegal = 1'b1;
        endcase
        r.rd_we    = wr && !r.illegal && r.rd != 5'd0;
        r.rd_value = r.rd_we ? val : '0;
        if (r.rd_we) begin
            regs[r.rd] = val;
        end
        return r;
    endfunction

    task automatic compare_field(string name, rv32i_word got, rv32i_word exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: out_rec.%s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_record(retire_t exp);
        compare_field("pc", out_rec.pc, exp.pc);
        compare_field("next_pc", out_rec.next_pc, exp.next_pc);
        compare_field("rd", 32'(out_rec.rd), 32'(exp.rd));
        compare_field("rd_we", 32'(out_rec.rd_we), 32'(exp.rd_we));
        compare_field("rd_value", out_rec.rd_value, exp.rd_value);
        compare_field("load_pending", 32'(out_rec.load_pending), 32'(exp.load_pending));
        compare_field("mem_read", 32'(out_rec.mem_read), 32'(exp.mem_read));
        compare_field("mem_write", 32'(out_rec.mem_write), 32'(exp.mem_write));
        compare_field("mem_addr", out_rec.mem_addr, exp.mem_addr);
        compare_field("mem_wdata", out_rec.mem_wdata, exp.mem_wdata);
        compare_field("mem_byte_en", 32'(out_rec.mem_byte_en), 32'(exp.mem_byte_en));
        compare_field("illegal", 32'(out_rec.illegal), 32'(exp.illegal));
    endtask

    always @(posedge clk) begin
        // one reset edge already passed, so the pipeline must be empty
        if (reset_seen && (out_valid !== 1'b0 || in_ready !== 1'b0)) begin
            other_errors++;
            $display("Error at %0t: out_valid or in_ready is high during reset", $time);
        end
        reset_seen = !rst_n;
        if (!rst_n) begin
            foreach (regs[i]) begin
                regs[i] = '0;
            end
            expected.delete();
        end else begin
            if (in_valid && in_ready) begin
                expected.push_back(run_model(in_pc, in_instr));
            end
            if (out_valid && out_ready) begin
                if (expected.size() == 0) begin
                    other_errors++;
                    $display("Error at %0t: a record came out with no instruction in flight",
                             $time);
                end else begin
                    exp_rec = expected.pop_front();
                    compare_record(exp_rec);
                end
            end
        end
        pending = expected.size();
    end

endmodule

// File: test/tb_top.sv
`timescale 1ns/10ps

module tb_top
    import rv32i_types::*;
();
    localparam int NUM_INSTR = 2000;
    localparam int TIMEOUT   = 2000;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    rv32i_word  in_pc;
    rv32i_word  in_instr;
    logic       out_valid;
    logic       out_ready;
    retire_t    out_rec;
    logic       accepted;
    int         seed;
    int         timeouts;
    int         mismatches;
    int         other_errors;
    int         pending;
    logic [6:0] bad_ops [4] = '{7'b1110011, 7'b0001111, 7'b0000000, 7'b1111111};

    rv32i_datapath dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pc     (in_pc),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rec   (out_rec)
    );

    result_checker u_result_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pc        (in_pc),
        .in_instr     (in_instr),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_rec      (out_rec),
        .mismatches   (mismatches),
        .other_errors (other_errors),
        .pending      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // input handshake seen on the last rising edge
    always @(posedge clk) begin
        accepted <= rst_n && in_valid && in_ready;
    end

    function automatic int rand_below(int limit);
        return int'({$random(seed)} % limit);
    endfunction

    function automatic logic chance(int pct);
        return rand_below(100) < pct;
    endfunction

    function automatic rv32i_word gen_instr();
        int         pick;
        logic [6:0] opcode;
        rv32i_word  instr;
        pick = rand_below(100);
        if (pick < 4)       opcode = bad_ops[rand_below(4)];
        else if (pick < 10) opcode = op_lui;
        else if (pick < 16) opcode = op_auipc;
        else if (pick < 22) opcode = op_jal;
        else if (pick < 28) opcode = op_jalr;
        else if (pick < 44) opcode = op_br;
        else if (pick < 56) opcode = op_load;
        else if (pick < 68) opcode = op_store;
        else if (pick < 84) opcode = op_imm;
        else                opcode = op_reg;
        instr        = $random(seed); // funct7 and upper immediate bits
        instr[6:0]   = opcode;
        instr[11:7]  = 5'(rand_below(6)); // small pool, many dependent pairs
        if (opcode != op_lui && opcode != op_auipc && opcode != op_jal) begin
            instr[14:12] = 3'(rand_below(8));
            instr[19:15] = 5'(rand_below(6));
            instr[24:20] = 5'(rand_below(6));
        end
        if (opcode == op_store) begin
            instr[14:12] = 3'(rand_below(4)); // mostly legal widths
        end
        return instr;
    endfunction

    initial begin
        int n;
        int stall;
        int waited;
        seed      = 32'h31d9_f29d;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_instr  = '0;
        out_ready = 1'b0;
        timeouts  = 0;
        n         = 0;
        stall     = 0;
        waited    = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (n < NUM_INSTR && timeouts == 0) begin
            @(negedge clk);
            out_ready = chance(70);
            stall++;
            if (in_valid && accepted) begin
                n++;
                stall    = 0;
                in_valid = 1'b0;
            end else if (stall >= TIMEOUT) begin
                $display("Error at %0t: no instruction accepted for %0d cycles", $time, TIMEOUT);
                timeouts++;
            end
            if (!in_valid && n < NUM_INSTR && timeouts == 0 && chance(70)) begin
                in_valid = 1'b1;
                in_pc    = rv32i_word'({$random(seed)}) & ~32'd3;
                in_instr = gen_instr();
            end
        end
        in_valid = 1'b0;

        // drain whatever is still in flight
        while (pending != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            out_ready = chance(70);
            waited++;
        end
        if (pending != 0) begin
            $display("Error at %0t: %0d records never came out", $time, pending);
            timeouts++;
        end

        $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatches, other_errors, timeouts);
        if (mismatches + other_errors + timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: rv32i_datapath.f
rtl/rv32i_types.sv
rtl/control_rom.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv32i_datapath.sv
test/result_checker.sv
test/tb_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_top
FILELIST  = rv32i_datapath.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
